/* flicky_pkg.sv */
`default_nettype none

package flicky_pkg;

	typedef enum logic [2:0] {
		region_none,
		region_cpu,
		region_snd,
		region_spr,
		region_tile
	} rom_region_e;

	// download byte map
	localparam logic [24:0] cpu_base        = 25'h00000;
	localparam logic [24:0] cpu_size        = 25'h08000;
	localparam logic [24:0] snd_base        = 25'h08000;
	localparam logic [24:0] snd_size        = 25'h02000;
	localparam logic [24:0] spr_base        = 25'h0C000;
	localparam logic [24:0] spr_size        = 25'h08000;
	localparam logic [24:0] tile_base       = 25'h14000;
	localparam logic [24:0] tile_plane_size = 25'h04000; // three planes back to back

	// where each region starts in the 16-bit program memory
	localparam logic [15:0] cpu_word_base = 16'd0;
	localparam logic [15:0] snd_word_base = 16'd16384;
	localparam logic [15:0] spr_word_base = 16'd20480;

	localparam int prog_words = 36864;
	localparam int tile_words = 16384;

	// ps/2 set 2 codes
	localparam logic [7:0] key_left   = 8'h6B;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_fire   = 8'h14; // left ctrl
	localparam logic [7:0] key_start1 = 8'h16;
	localparam logic [7:0] key_start2 = 8'h1E;
	localparam logic [7:0] key_coin   = 8'h2E;

	localparam int reset_stretch = 16;
	localparam int stretch_bits  = $clog2(reset_stretch);

endpackage

`default_nettype wire

/* ioctl_capture.sv */
`default_nettype none

module ioctl_capture (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire         ioctl_download,
	input  wire         ioctl_wr,
	input  wire  [24:0] ioctl_addr,
	input  wire  [7:0]  ioctl_dout,
	output logic        wr_pulse,
	output logic [24:0] wr_addr,
	output logic [7:0]  wr_data,
	output logic        loaded
);

	logic wr_q;
	logic dl_q;
	logic wr_rise;

	// only edges inside a download count
	assign wr_rise = ioctl_download & ioctl_wr & ~wr_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_q     <= 1'b0;
			dl_q     <= 1'b0;
			wr_pulse <= 1'b0;
			loaded   <= 1'b0;
		end else begin
			wr_q     <= ioctl_wr;
			dl_q     <= ioctl_download;
			wr_pulse <= wr_rise;
			if (dl_q & ~ioctl_download)
				loaded <= 1'b1; // sticky until reset
		end
	end

	// address and data held stable with the pulse
	always_ff @(posedge clk_sys) begin
		if (wr_rise) begin
			wr_addr <= ioctl_addr;
			wr_data <= ioctl_dout;
		end
	end

endmodule

`default_nettype wire

/* arcade_input_map.sv */
`default_nettype none

module arcade_input_map import flicky_pkg::*; (
	input  wire        clk_sys,
	input  wire        arst_n,
	input  wire        key_strobe,
	input  wire        key_pressed,
	input  wire  [7:0] key_code,
	input  wire  [7:0] joystick_0,
	input  wire  [7:0] joystick_1,
	output logic [7:0] inp0,
	output logic [7:0] inp1,
	output logic [7:0] inp2
);

	logic k_left;
	logic k_right;
	logic k_fire;
	logic k_start1;
	logic k_start2;
	logic k_coin;

	logic p1_left;
	logic p1_right;
	logic p1_fire;

	// keyboard state, one flag per known key
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			k_left   <= 1'b0;
			k_right  <= 1'b0;
			k_fire   <= 1'b0;
			k_start1 <= 1'b0;
			k_start2 <= 1'b0;
			k_coin   <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				key_left:   k_left   <= key_pressed;
				key_right:  k_right  <= key_pressed;
				key_fire:   k_fire   <= key_pressed;
				key_start1: k_start1 <= key_pressed;
				key_start2: k_start2 <= key_pressed;
				key_coin:   k_coin   <= key_pressed;
				default: ; // unknown code ignored
			endcase
		end
	end

	// joystick bits: 0 right, 1 left, 4 fire
	assign p1_left  = k_left | joystick_0[1];
	assign p1_right = k_right | joystick_0[0];
	assign p1_fire  = k_fire | joystick_0[4];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			inp0 <= 8'hFF;
			inp1 <= 8'hFF;
			inp2 <= 8'hFF;
		end else begin
			inp0 <= ~{p1_left, p1_right, 3'b000, p1_fire, 2'b00};
			inp1 <= ~{joystick_1[1], joystick_1[0], 3'b000, joystick_1[4], 2'b00};
			inp2 <= ~{2'b00, k_start2, k_start1, 3'b000, k_coin};
		end
	end

endmodule

`default_nettype wire

/* rom_region_map.sv */
`default_nettype none

module rom_region_map import flicky_pkg::*; (
	input  wire  [24:0] wr_addr,
	output rom_region_e wr_region,
	output logic [15:0] prog_addr,
	output logic [13:0] tile_addr,
	output logic [1:0]  lane
);

	logic [24:0] cpu_off;
	logic [24:0] snd_off;
	logic [24:0] spr_off;
	logic [24:0] tile_off;

	// below a base the offset wraps high, so one compare per region
	assign cpu_off  = wr_addr - cpu_base;
	assign snd_off  = wr_addr - snd_base;
	assign spr_off  = wr_addr - spr_base;
	assign tile_off = wr_addr - tile_base;

	always_comb begin
		wr_region = region_none;
		prog_addr = 16'd0;
		tile_addr = tile_off[13:0]; // offset within a plane
		lane      = {1'b0, wr_addr[0]};

		if (cpu_off < cpu_size) begin
			wr_region = region_cpu;
			prog_addr = cpu_word_base + cpu_off[16:1];
		end else if (snd_off < snd_size) begin
			wr_region = region_snd;
			prog_addr = snd_word_base + snd_off[16:1];
		end else if (spr_off < spr_size) begin
			wr_region = region_spr;
			prog_addr = spr_word_base + spr_off[16:1];
		end else if (tile_off < 3 * tile_plane_size) begin
			// plane number picks the byte of the 24-bit word
			wr_region = region_tile;
			lane      = tile_off[15:14];
		end
	end

endmodule

`default_nettype wire

/* core_control.sv */
`default_nettype none

module core_control import flicky_pkg::*; (
	input  wire        clk_sys,
	input  wire        arst_n,
	input  wire [15:0] status,
	input  wire [1:0]  buttons,
	input  wire        loaded,
	output logic       game_reset,
	output logic [7:0] dsw1
);

	typedef enum logic [1:0] {
		st_hold,
		st_count,
		st_run
	} ctl_state_e;

	ctl_state_e state;
	logic [stretch_bits-1:0] cnt;
	logic req;

	// osd reset, reset button, or roms not there yet
	assign req = ~loaded | status[0] | buttons[1];

	assign game_reset = (state != st_run);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_hold;
			cnt   <= '0;
		end else if (req) begin
			state <= st_hold; // restart the stretch
			cnt   <= '0;
		end else begin
			case (state)
				st_hold: begin
					state <= st_count;
					cnt   <= stretch_bits'(1); // first quiet cycle
				end
				st_count: begin
					if (cnt == stretch_bits'(reset_stretch - 1))
						state <= st_run;
					cnt <= cnt + 1'b1;
				end
				default: ;
			endcase
		end
	end

	// difficulty, extend, lives
	always_ff @(posedge clk_sys) begin
		dsw1 <= {~status[12], ~status[11:10], ~status[9:8], 2'b00};
	end

endmodule

`default_nettype wire

/* rom_store.sv */
`default_nettype none

module rom_store import flicky_pkg::*; (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire         ioctl_download,
	input  wire         wr_pulse,
	input  rom_region_e wr_region,
	input  wire  [15:0] prog_addr,
	input  wire  [13:0] tile_addr,
	input  wire  [1:0]  lane,
	input  wire  [7:0]  wr_data,
	input  wire  [14:0] cpu_rom_addr,
	input  wire  [12:0] snd_rom_addr,
	input  wire  [14:0] spr_rom_addr,
	input  wire  [13:0] tile_rom_addr,
	output logic [7:0]  cpu_rom_data,
	output logic [7:0]  snd_rom_data,
	output logic [7:0]  spr_rom_data,
	output logic [23:0] tile_rom_data
);

	logic [15:0] prog_mem [prog_words];
	logic [23:0] tile_mem [tile_words];

	logic [15:0] cpu_word;
	logic [15:0] snd_word;
	logic [15:0] spr_word;
	logic [23:0] tile_word;
	logic        cpu_sel;
	logic        snd_sel;
	logic        spr_sel;

	function automatic logic [7:0] pick_byte(input logic [15:0] word, input logic hi);
		return hi ? word[15:8] : word[7:0];
	endfunction

	// one byte lane per download write
	always_ff @(posedge clk_sys) begin
		if (wr_pulse) begin
			case (wr_region)
				region_cpu, region_snd, region_spr: begin
					if (lane[0])
						prog_mem[prog_addr][15:8] <= wr_data;
					else
						prog_mem[prog_addr][7:0] <= wr_data;
				end
				region_tile: begin
					case (lane)
						2'd0: tile_mem[tile_addr][7:0]   <= wr_data;
						2'd1: tile_mem[tile_addr][15:8]  <= wr_data;
						2'd2: tile_mem[tile_addr][23:16] <= wr_data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// game side reads, word index is region base plus address / 2
	always_ff @(posedge clk_sys) begin
		cpu_word  <= prog_mem[cpu_word_base + {2'b00, cpu_rom_addr[14:1]}];
		snd_word  <= prog_mem[snd_word_base + {4'b0000, snd_rom_addr[12:1]}];
		spr_word  <= prog_mem[spr_word_base + {2'b00, spr_rom_addr[14:1]}];
		tile_word <= tile_mem[tile_rom_addr];
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cpu_sel <= 1'b0;
			snd_sel <= 1'b0;
			spr_sel <= 1'b0;
		end else begin
			cpu_sel <= cpu_rom_addr[0];
			snd_sel <= snd_rom_addr[0];
			spr_sel <= spr_rom_addr[0];
		end
	end

	// memory belongs to the loader while downloading
	assign cpu_rom_data  = ioctl_download ? 8'h00 : pick_byte(cpu_word, cpu_sel);
	assign snd_rom_data  = ioctl_download ? 8'h00 : pick_byte(snd_word, snd_sel);
	assign spr_rom_data  = ioctl_download ? 8'h00 : pick_byte(spr_word, spr_sel);
	assign tile_rom_data = ioctl_download ? 24'h000000 : tile_word;

endmodule

`default_nettype wire

/* flicky_host.sv */
`default_nettype none

module flicky_host import flicky_pkg::*; (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire         ioctl_download,
	input  wire         ioctl_wr,
	input  wire  [24:0] ioctl_addr,
	input  wire  [7:0]  ioctl_dout,
	input  wire  [15:0] status,
	input  wire  [1:0]  buttons,
	input  wire         key_strobe,
	input  wire         key_pressed,
	input  wire  [7:0]  key_code,
	input  wire  [7:0]  joystick_0,
	input  wire  [7:0]  joystick_1,
	input  wire  [14:0] cpu_rom_addr,
	input  wire  [12:0] snd_rom_addr,
	input  wire  [14:0] spr_rom_addr,
	input  wire  [13:0] tile_rom_addr,
	output logic [7:0]  cpu_rom_data,
	output logic [7:0]  snd_rom_data,
	output logic [7:0]  spr_rom_data,
	output logic [23:0] tile_rom_data,
	output logic [7:0]  inp0,
	output logic [7:0]  inp1,
	output logic [7:0]  inp2,
	output logic [7:0]  dsw1,
	output logic        game_reset
);

	logic        wr_pulse;
	logic [24:0] wr_addr;
	logic [7:0]  wr_data;
	logic        loaded;
	rom_region_e wr_region;
	logic [15:0] prog_addr;
	logic [13:0] tile_addr;
	logic [1:0]  lane;

	ioctl_capture u_ioctl_capture (
		.clk_sys, .arst_n,
		.ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
		.wr_pulse, .wr_addr, .wr_data, .loaded
	);

	rom_region_map u_rom_region_map (
		.wr_addr, .wr_region, .prog_addr, .tile_addr, .lane
	);

	rom_store u_rom_store (
		.clk_sys, .arst_n, .ioctl_download,
		.wr_pulse, .wr_region, .prog_addr, .tile_addr, .lane, .wr_data,
		.cpu_rom_addr, .snd_rom_addr, .spr_rom_addr, .tile_rom_addr,
		.cpu_rom_data, .snd_rom_data, .spr_rom_data, .tile_rom_data
	);

	arcade_input_map u_arcade_input_map (
		.clk_sys, .arst_n,
		.key_strobe, .key_pressed, .key_code,
		.joystick_0, .joystick_1,
		.inp0, .inp1, .inp2
	);

	core_control u_core_control (
		.clk_sys, .arst_n,
		.status, .buttons, .loaded,
		.game_reset, .dsw1
	);

endmodule

`default_nettype wire

/* tb_flicky_host.sv */
`default_nettype none

module tb_flicky_host import flicky_pkg::*; ();

	typedef enum logic [3:0] {
		op_joy, op_key, op_status, op_release, op_dl_on, op_dl_off,
		op_wr, op_rd_cpu, op_rd_snd, op_rd_spr, op_rd_tile
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_val;
	} row_t;

	logic        clk_sys;
	logic        arst_n;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [15:0] status;
	logic [1:0]  buttons;
	logic        key_strobe;
	logic        key_pressed;
	logic [7:0]  key_code;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [14:0] cpu_rom_addr;
	logic [12:0] snd_rom_addr;
	logic [14:0] spr_rom_addr;
	logic [13:0] tile_rom_addr;
	wire  [7:0]  cpu_rom_data;
	wire  [7:0]  snd_rom_data;
	wire  [7:0]  spr_rom_data;
	wire  [23:0] tile_rom_data;
	wire  [7:0]  inp0;
	wire  [7:0]  inp1;
	wire  [7:0]  inp2;
	wire  [7:0]  dsw1;
	wire         game_reset;

	// reference model stepped while the table is built
	logic [7:0]  byte_model [int];
	logic        dl_model;
	logic        rst_model;
	logic [5:0]  key_model; // left right fire start1 start2 coin
	logic [7:0]  joy0_model;
	logic [7:0]  joy1_model;
	row_t        rows [$];
	int          errors;
	int          checks;
	bit          table_ready;

	flicky_host u_flicky_host (.*);

	always #10 clk_sys = ~clk_sys;

	function automatic bit in_any_region(input logic [24:0] a);
		return (a < cpu_base + cpu_size)
			|| (a >= snd_base && a < snd_base + snd_size)
			|| (a >= spr_base && a < spr_base + spr_size)
			|| (a >= tile_base && a < tile_base + tile_plane_size * 3);
	endfunction

	function automatic logic [7:0] stored_byte(input logic [24:0] a);
		return byte_model.exists(int'(a)) ? byte_model[int'(a)] : 8'h00;
	endfunction

	function automatic logic [7:0] dsw_expect(input logic [15:0] s);
		return {~s[12], ~s[11:10], ~s[9:8], 2'b00};
	endfunction

	function automatic logic [23:0] inputs_expect();
		logic l;
		logic r;
		logic f;
		l = key_model[0] | joy0_model[1];
		r = key_model[1] | joy0_model[0];
		f = key_model[2] | joy0_model[4];
		return {~{2'b00, key_model[4], key_model[3], 3'b000, key_model[5]},
			~{joy1_model[1], joy1_model[0], 3'b000, joy1_model[4], 2'b00},
			~{l, r, 3'b000, f, 2'b00}};
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at time %0t: %s got 0x%0h expected 0x%0h",
				$time, msg, actual, expected);
		end
	endtask

	task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data);
		row_t        r;
		logic [31:0] ex;
		logic [24:0] a;
		ex = 32'd0;
		a  = addr[24:0];
		case (op)
			op_dl_on: begin
				dl_model = 1'b1;
				ex = 32'd1;
			end
			op_dl_off: begin
				dl_model  = 1'b0;
				rst_model = 1'b0;
				ex = reset_stretch + 1; // loaded lags the download by a cycle
			end
			op_wr: begin
				if (dl_model && in_any_region(a))
					byte_model[int'(a)] = data[7:0];
				ex = {31'd0, rst_model};
			end
			op_rd_cpu: ex = dl_model ? 32'd0 : {24'd0, stored_byte(cpu_base + a)};
			op_rd_snd: ex = dl_model ? 32'd0 : {24'd0, stored_byte(snd_base + a)};
			op_rd_spr: ex = dl_model ? 32'd0 : {24'd0, stored_byte(spr_base + a)};
			op_rd_tile: ex = dl_model ? 32'd0 : {8'd0,
				stored_byte(tile_base + tile_plane_size + tile_plane_size + a),
				stored_byte(tile_base + tile_plane_size + a),
				stored_byte(tile_base + a)};
			op_key: begin
				case (addr[7:0])
					key_left:   key_model[0] = data[0];
					key_right:  key_model[1] = data[0];
					key_fire:   key_model[2] = data[0];
					key_start1: key_model[3] = data[0];
					key_start2: key_model[4] = data[0];
					key_coin:   key_model[5] = data[0];
					default: ;
				endcase
				ex = {8'd0, inputs_expect()};
			end
			op_joy: begin
				joy0_model = addr[7:0];
				joy1_model = data[7:0];
				ex = {8'd0, inputs_expect()};
			end
			op_status: begin
				if (addr[0] || data[1])
					rst_model = 1'b1;
				ex = {23'd0, rst_model, dsw_expect(addr[15:0])};
			end
			default: begin
				rst_model = 1'b0;
				ex = reset_stretch;
			end
		endcase
		r.op      = op;
		r.addr    = addr;
		r.data    = data;
		r.exp_val = ex;
		rows.push_back(r);
	endtask

	task automatic build_table();
		int unsigned in_region [16];
		int unsigned off_region [6];
		logic [31:0] s;
		in_region = '{32'h00000, 32'h00001, 32'h07FFE, 32'h07FFF, 32'h08000, 32'h08001,
			32'h09FFF, 32'h0C000, 32'h0C001, 32'h13FFF, 32'h14123, 32'h18123,
			32'h1C123, 32'h17FFF, 32'h1BFFF, 32'h1FFFF};
		off_region = '{32'h0A000, 32'h0A001, 32'h0BFFF, 32'h20000, 32'h20001, 32'h28123};
		dl_model   = 1'b0;
		rst_model  = 1'b1;
		key_model  = '0;
		joy0_model = '0;
		joy1_model = '0;
		add_row(op_joy, 0, 0);
		add_row(op_status, 0, 0);
		add_row(op_dl_on, 0, 0);
		foreach (in_region[k])
			add_row(op_wr, in_region[k], $urandom & 32'hFF);
		add_row(op_rd_cpu, 0, 0); // store hidden while loading
		add_row(op_rd_spr, 1, 0);
		add_row(op_rd_tile, 32'h123, 0);
		foreach (off_region[k])
			add_row(op_wr, off_region[k], $urandom & 32'hFF);
		add_row(op_dl_off, 0, 0);
		add_row(op_wr, 32'h00000, $urandom & 32'hFF); // ignored outside a download
		add_row(op_wr, 32'h08001, $urandom & 32'hFF);
		add_row(op_wr, 32'h14123, $urandom & 32'hFF);
		add_row(op_rd_cpu, 0, 0);
		add_row(op_rd_cpu, 1, 0);
		add_row(op_rd_cpu, 32'h7FFE, 0);
		add_row(op_rd_cpu, 32'h7FFF, 0);
		add_row(op_rd_snd, 0, 0);
		add_row(op_rd_snd, 1, 0);
		add_row(op_rd_snd, 32'h1FFF, 0);
		add_row(op_rd_spr, 0, 0);
		add_row(op_rd_spr, 1, 0);
		add_row(op_rd_spr, 32'h7FFF, 0);
		add_row(op_rd_tile, 32'h123, 0);
		add_row(op_rd_tile, 32'h3FFF, 0);
		add_row(op_key, key_left, 1);
		add_row(op_key, key_right, 1);
		add_row(op_key, key_fire, 1);
		add_row(op_key, key_start1, 1);
		add_row(op_key, key_start2, 1);
		add_row(op_key, key_coin, 1);
		add_row(op_key, 32'h1C, 1);
		add_row(op_key, key_left, 0);
		add_row(op_key, key_fire, 0);
		add_row(op_key, key_coin, 0);
		add_row(op_key, 32'h75, 0);
		add_row(op_key, key_right, 0);
		repeat (4)
			add_row(op_joy, $urandom & 32'hFF, $urandom & 32'hFF);
		add_row(op_key, key_left, 1);
		add_row(op_joy, 0, 0);
		repeat (3)
			add_row(op_status, $urandom & 32'hFFFE, 0);
		add_row(op_status, 32'h1F00, 0);
		s = $urandom & 32'hFFFE;
		add_row(op_status, s | 32'h1, 0); // osd reset request
		add_row(op_release, s, 0);
		add_row(op_status, s, 2); // reset button
		add_row(op_release, s, 0);
	endtask

	task automatic apply_row(input row_t r, input int idx);
		int    i;
		string tag;
		tag = $sformatf("row %0d", idx);
		@(posedge clk_sys);
		case (r.op)
			op_dl_on:  ioctl_download <= 1'b1;
			op_dl_off: ioctl_download <= 1'b0;
			op_wr: begin
				ioctl_addr <= r.addr[24:0];
				ioctl_dout <= r.data[7:0];
				ioctl_wr   <= 1'b1;
			end
			op_rd_cpu:  cpu_rom_addr  <= r.addr[14:0];
			op_rd_snd:  snd_rom_addr  <= r.addr[12:0];
			op_rd_spr:  spr_rom_addr  <= r.addr[14:0];
			op_rd_tile: tile_rom_addr <= r.addr[13:0];
			op_key: begin
				key_strobe  <= 1'b1;
				key_code    <= r.addr[7:0];
				key_pressed <= r.data[0];
			end
			op_joy: begin
				joystick_0 <= r.addr[7:0];
				joystick_1 <= r.data[7:0];
			end
			default: begin
				status  <= r.addr[15:0];
				buttons <= r.data[1:0];
			end
		endcase
		if (r.op == op_dl_off || r.op == op_release) begin
			// held in reset up to the last counted cycle
			for (i = 1; i <= int'(r.exp_val); i++) begin
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_eq({31'd0, game_reset}, {31'd0, i < int'(r.exp_val)},
					{tag, " game reset release"});
			end
		end else begin
			@(posedge clk_sys);
			ioctl_wr   <= 1'b0;
			key_strobe <= 1'b0;
			@(negedge clk_sys);
			// one register stage after the drive
			case (r.op)
				op_rd_cpu:  check_eq({24'd0, cpu_rom_data}, r.exp_val, {tag, " cpu rom"});
				op_rd_snd:  check_eq({24'd0, snd_rom_data}, r.exp_val, {tag, " sound rom"});
				op_rd_spr:  check_eq({24'd0, spr_rom_data}, r.exp_val, {tag, " sprite rom"});
				op_rd_tile: check_eq({8'd0, tile_rom_data}, r.exp_val, {tag, " tile rom"});
				op_joy:
					check_eq({8'd0, inp2, inp1, inp0}, r.exp_val, {tag, " input bytes"});
				op_status:
					check_eq({23'd0, game_reset, dsw1}, r.exp_val, {tag, " reset and dsw1"});
				default: ;
			endcase
			@(posedge clk_sys);
			@(negedge clk_sys);
			case (r.op)
				op_key: // key flag first, then the byte
					check_eq({8'd0, inp2, inp1, inp0}, r.exp_val, {tag, " input bytes"});
				op_wr, op_dl_on:
					check_eq({31'd0, game_reset}, r.exp_val, {tag, " game reset"});
				default: ;
			endcase
		end
	endtask

	initial begin : main
		clk_sys        = 1'b0;
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		status         = '0;
		buttons        = '0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		cpu_rom_addr   = '0;
		snd_rom_addr   = '0;
		spr_rom_addr   = '0;
		tile_rom_addr  = '0;
		errors         = 0;
		checks         = 0;
		void'($urandom(32'he2d1_b957));
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk_sys);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);
		foreach (rows[k])
			apply_row(rows[k], k);
		repeat (2) @(posedge clk_sys);
		$display("rows: %0d checks: %0d errors: %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// 40 cycles per row is far above the longest row
	initial begin : watchdog
		wait (table_ready);
		repeat (rows.size() * 40 + 400) @(posedge clk_sys);
		$display("timeout: the table did not finish in the allowed number of cycles");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flicky_host.f */
flicky_pkg.sv
ioctl_capture.sv
arcade_input_map.sv
rom_region_map.sv
core_control.sv
rom_store.sv
flicky_host.sv
tb_flicky_host.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_flicky_host -Mdir obj_dir -f flicky_host.f

out=$(./obj_dir/Vtb_flicky_host)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS"
